// File: neuronLayer.sv
`default_nettype none

module neuronLayer import nnPkg::*; #(
	parameter int numIn = 15,
	parameter int numOut = 4
) (
	input logic clk,
	input logic reset,
	input logic validIn,
	input actT actsIn [numIn],
	input weightT weights [numOut][numIn],
	input biasT biases [numOut],
	output logic validOut,
	output actT actsOut [numOut]
);

	accT sumNext [numOut];
	accT sumReg [numOut];
	logic validMid;

	// activations are unsigned, so they are zero-extended before the signed multiply.
	always_comb
	begin
		for (int n = 0; n < numOut; n++)
		begin
			sumNext[n] = accT'(biases[n]);
			for (int i = 0; i < numIn; i++)
				sumNext[n] = sumNext[n] + accT'(actsIn[i]) * accT'(weights[n][i]);
		end
	end

	// stage 1 holds the raw sums.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validMid <= 1'b0;
			for (int n = 0; n < numOut; n++)
				sumReg[n] <= '0;
		end
		else
		begin
			validMid <= validIn;
			sumReg <= sumNext;
		end
	end

	// stage 2 holds the rectified activations.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validOut <= 1'b0;
			for (int n = 0; n < numOut; n++)
				actsOut[n] <= '0;
		end
		else
		begin
			validOut <= validMid;
			for (int n = 0; n < numOut; n++)
				actsOut[n] <= activate(sumReg[n]);
		end
	end

endmodule

`default_nettype wire

// File: nnApbRegs.sv
`default_nettype none

module nnApbRegs import nnPkg::*; #(
	parameter int numInputs = 15,
	parameter int numHidden = 4,
	parameter int numOutputs = 2
) (
	input logic clk,
	input logic reset,
	input apbReqT apbReq,
	output apbRspT apbRsp,
	output logic start,
	output actT inputActs [numInputs],
	output weightT hiddenWeights [numHidden][numInputs],
	output biasT hiddenBiases [numHidden],
	output weightT outWeights [numOutputs][numHidden],
	output biasT outBiases [numOutputs],
	input logic resultValid,
	input actT resultActs [numOutputs]
);

	logic done;
	actT resultRegs [numOutputs];

	logic access;
	logic wrEn;
	logic startWrite;
	logic hitCtrl, hitStatus, hitResult, hitInput;
	logic hitHw, hitHb, hitOw, hitOb;
	logic mapped;
	logic err;
	logic [31:0] rdata;
	int resultIdx, inputIdx, hwIdx, hbIdx, owIdx, obIdx;

	// only word-aligned addresses inside a region count as a hit.
	function automatic logic inRegion(logic [11:0] addr, logic [11:0] base, int count);
		int offset;
		offset = int'(addr) - int'(base);
		return (addr[1:0] == 2'b00) && (offset >= 0) && (offset < 4 * count);
	endfunction

	function automatic int wordIndex(logic [11:0] addr, logic [11:0] base);
		return (int'(addr) - int'(base)) >>> 2;
	endfunction

	assign access = apbReq.sel && apbReq.enable;

	assign hitCtrl = inRegion(apbReq.addr, addrCtrl, 1);
	assign hitStatus = inRegion(apbReq.addr, addrStatus, 1);
	assign hitResult = inRegion(apbReq.addr, addrResult, numOutputs);
	assign hitInput = inRegion(apbReq.addr, addrInput, numInputs);
	assign hitHw = inRegion(apbReq.addr, addrHiddenWeight, numHidden * numInputs);
	assign hitHb = inRegion(apbReq.addr, addrHiddenBias, numHidden);
	assign hitOw = inRegion(apbReq.addr, addrOutWeight, numOutputs * numHidden);
	assign hitOb = inRegion(apbReq.addr, addrOutBias, numOutputs);

	assign resultIdx = wordIndex(apbReq.addr, addrResult);
	assign inputIdx = wordIndex(apbReq.addr, addrInput);
	assign hwIdx = wordIndex(apbReq.addr, addrHiddenWeight);
	assign hbIdx = wordIndex(apbReq.addr, addrHiddenBias);
	assign owIdx = wordIndex(apbReq.addr, addrOutWeight);
	assign obIdx = wordIndex(apbReq.addr, addrOutBias);

	assign mapped = hitCtrl || hitStatus || hitResult || hitInput
		|| hitHw || hitHb || hitOw || hitOb;
	// status and results are read-only, so writing them is an error too.
	assign err = access && (!mapped || (apbReq.write && (hitStatus || hitResult)));
	assign wrEn = access && apbReq.write && !err;
	assign startWrite = wrEn && hitCtrl && apbReq.wdata[0];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			start <= 1'b0;
			done <= 1'b0;
			for (int r = 0; r < numOutputs; r++)
				resultRegs[r] <= '0;
			for (int i = 0; i < numInputs; i++)
				inputActs[i] <= '0;
			for (int n = 0; n < numHidden; n++)
			begin
				hiddenBiases[n] <= '0;
				for (int i = 0; i < numInputs; i++)
					hiddenWeights[n][i] <= '0;
			end
			for (int n = 0; n < numOutputs; n++)
			begin
				outBiases[n] <= '0;
				for (int i = 0; i < numHidden; i++)
					outWeights[n][i] <= '0;
			end
		end
		else
		begin
			start <= startWrite;
			if (resultValid)
			begin
				done <= 1'b1;
				resultRegs <= resultActs;
			end
			// a fresh start wins over a result landing on the same edge.
			if (startWrite)
				done <= 1'b0;
			for (int i = 0; i < numInputs; i++)
				if (wrEn && hitInput && inputIdx == i)
					inputActs[i] <= apbReq.wdata[7:0];
			for (int n = 0; n < numHidden; n++)
			begin
				if (wrEn && hitHb && hbIdx == n)
					hiddenBiases[n] <= apbReq.wdata[15:0];
				for (int i = 0; i < numInputs; i++)
					if (wrEn && hitHw && hwIdx == n * numInputs + i)
						hiddenWeights[n][i] <= apbReq.wdata[7:0];
			end
			for (int n = 0; n < numOutputs; n++)
			begin
				if (wrEn && hitOb && obIdx == n)
					outBiases[n] <= apbReq.wdata[15:0];
				for (int i = 0; i < numHidden; i++)
					if (wrEn && hitOw && owIdx == n * numHidden + i)
						outWeights[n][i] <= apbReq.wdata[7:0];
			end
		end
	end

	// ctrl has no stored state and reads back as 0.
	always_comb
	begin
		rdata = '0;
		if (access && !apbReq.write && !err)
		begin
			if (hitStatus)
				rdata = {31'b0, done};
			for (int r = 0; r < numOutputs; r++)
				if (hitResult && resultIdx == r)
					rdata = {24'b0, resultRegs[r]};
			for (int i = 0; i < numInputs; i++)
				if (hitInput && inputIdx == i)
					rdata = {24'b0, inputActs[i]};
			for (int n = 0; n < numHidden; n++)
			begin
				if (hitHb && hbIdx == n)
					rdata = {{16{hiddenBiases[n][15]}}, hiddenBiases[n]};
				for (int i = 0; i < numInputs; i++)
					if (hitHw && hwIdx == n * numInputs + i)
						rdata = {{24{hiddenWeights[n][i][7]}}, hiddenWeights[n][i]};
			end
			for (int n = 0; n < numOutputs; n++)
			begin
				if (hitOb && obIdx == n)
					rdata = {{16{outBiases[n][15]}}, outBiases[n]};
				for (int i = 0; i < numHidden; i++)
					if (hitOw && owIdx == n * numHidden + i)
						rdata = {{24{outWeights[n][i][7]}}, outWeights[n][i]};
			end
		end
	end

	assign apbRsp = '{rdata: rdata, ready: 1'b1, slverr: err};

endmodule

`default_nettype wire

// File: nnPkg.sv
`default_nettype none

package nnPkg;

	typedef logic [7:0] actT;
	typedef logic signed [7:0] weightT;
	typedef logic signed [15:0] biasT;
	// wide enough for 15 products of 255 x 127 plus a full-scale bias.
	typedef logic signed [23:0] accT;

	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		logic [11:0] addr;
		logic [31:0] wdata;
	} apbReqT;

	typedef struct packed {
		logic [31:0] rdata;
		logic ready;
		logic slverr;
	} apbRspT;

	// byte addresses of the register regions.
	localparam logic [11:0] addrCtrl = 12'h000;
	localparam logic [11:0] addrStatus = 12'h004;
	localparam logic [11:0] addrResult = 12'h008;
	localparam logic [11:0] addrInput = 12'h040;
	localparam logic [11:0] addrHiddenWeight = 12'h100;
	localparam logic [11:0] addrHiddenBias = 12'h200;
	localparam logic [11:0] addrOutWeight = 12'h240;
	localparam logic [11:0] addrOutBias = 12'h280;

	// a clamped rectifier that scales the sum down by 32.
	function automatic actT activate(accT sum);
		if (sum < 0)
			return '0;
		else if (sum > 4096)
			return 8'hff;
		return sum[12:5];
	endfunction

endpackage

`default_nettype wire

// File: nnTop.sv
`default_nettype none

module nnTop import nnPkg::*; #(
	parameter int numInputs = 15,
	parameter int numHidden = 4,
	parameter int numOutputs = 2
) (
	input logic clk,
	input logic reset,
	input apbReqT apbReq,
	output apbRspT apbRsp
);

	logic start;
	actT inputActs [numInputs];
	weightT hiddenWeights [numHidden][numInputs];
	biasT hiddenBiases [numHidden];
	weightT outWeights [numOutputs][numHidden];
	biasT outBiases [numOutputs];
	logic hiddenValid;
	actT hiddenActs [numHidden];
	logic resultValid;
	actT resultActs [numOutputs];

	nnApbRegs #(
		.numInputs(numInputs),
		.numHidden(numHidden),
		.numOutputs(numOutputs)
	) u_regs (
		.clk(clk),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.start(start),
		.inputActs(inputActs),
		.hiddenWeights(hiddenWeights),
		.hiddenBiases(hiddenBiases),
		.outWeights(outWeights),
		.outBiases(outBiases),
		.resultValid(resultValid),
		.resultActs(resultActs)
	);

	// the start pulse is the sample valid for the hidden layer.
	neuronLayer #(
		.numIn(numInputs),
		.numOut(numHidden)
	) u_hidden (
		.clk(clk),
		.reset(reset),
		.validIn(start),
		.actsIn(inputActs),
		.weights(hiddenWeights),
		.biases(hiddenBiases),
		.validOut(hiddenValid),
		.actsOut(hiddenActs)
	);

	neuronLayer #(
		.numIn(numHidden),
		.numOut(numOutputs)
	) u_output (
		.clk(clk),
		.reset(reset),
		.validIn(hiddenValid),
		.actsIn(hiddenActs),
		.weights(outWeights),
		.biases(outBiases),
		.validOut(resultValid),
		.actsOut(resultActs)
	);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbNnTop -f src.f -o simNnTop > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/simNnTop > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

if grep -F -q '** FAIL **' sim.log; then
	echo "Simulation reported failure, see sim.log"
	exit 1
fi

echo "Simulation finished without failure"
exit 0

// File: src.f
+incdir+.
nnPkg.sv
nnApbRegs.sv
neuronLayer.sv
nnTop.sv
tbNnTop.sv

// File: tbNnCheck.svh
`ifndef TB_NN_CHECK_SVH
`define TB_NN_CHECK_SVH

function automatic logic [31:0] xorshift(logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// negative clamps to zero, anything above 4096 saturates, otherwise divide by 32.
function automatic actT rectifyRef(logic signed [23:0] s);
	if (s < 24'sd0)
		return 8'd0;
	if (s > 24'sd4096)
		return 8'd255;
	return s[12:5];
endfunction

function automatic actT refHidden(int n);
	logic signed [23:0] acc;
	logic signed [23:0] a;
	logic signed [23:0] w;
	acc = {{8{hb[n][15]}}, hb[n]};
	for (int i = 0; i < numInputs; i++)
	begin
		a = {16'b0, inVec[i]};
		w = {{16{hw[n][i][7]}}, hw[n][i]};
		acc = acc + a * w;
	end
	return rectifyRef(acc);
endfunction

function automatic actT refInfer(int o);
	logic signed [23:0] acc;
	logic signed [23:0] a;
	logic signed [23:0] w;
	acc = {{8{ob[o][15]}}, ob[o]};
	for (int h = 0; h < numHidden; h++)
	begin
		a = {16'b0, refHidden(h)};
		w = {{16{ow[o][h][7]}}, ow[o][h]};
		acc = acc + a * w;
	end
	return rectifyRef(acc);
endfunction

task automatic checkAct(string name, actT expected, actT actual);
	checks++;
	if (actual !== expected)
	begin
		errors++;
		$display("[FAIL] %0t %s expected %0d got %0d", $time, name, expected, actual);
	end
endtask

task automatic checkWord(string name, logic [31:0] expected, logic [31:0] actual);
	checks++;
	if (actual !== expected)
	begin
		errors++;
		$display("[FAIL] %0t %s expected %08h got %08h", $time, name, expected, actual);
	end
endtask

task automatic checkErr(string name, logic expected, logic actual);
	checks++;
	if (actual !== expected)
	begin
		errors++;
		$display("[FAIL] %0t %s expected %b got %b", $time, name, expected, actual);
	end
endtask

`endif

// File: tbNnTop.sv
`default_nettype none

module tbNnTop import nnPkg::*;;

	localparam int numInputs = 15;
	localparam int numHidden = 4;
	localparam int numOutputs = 2;

	logic clk;
	logic reset;
	apbReqT apbReq;
	apbRspT apbRsp;

	// testbench copies of everything written to the DUT.
	actT inVec [numInputs];
	weightT hw [numHidden][numInputs];
	biasT hb [numHidden];
	weightT ow [numOutputs][numHidden];
	biasT ob [numOutputs];

	int errors;
	int checks;
	logic [31:0] rngState;
	logic [31:0] rd;
	logic er;

	`include "tbNnCheck.svh"

	nnTop #(
		.numInputs(numInputs),
		.numHidden(numHidden),
		.numOutputs(numOutputs)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [11:0] regAddr(logic [11:0] base, int idx);
		return base + 12'(idx * 4);
	endfunction

	// called 1 time unit after a rising edge, returns at the same offset.
	task automatic apbCycle(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		apbReq.sel = 1'b1;
		apbReq.enable = 1'b0;
		apbReq.write = wr;
		apbReq.addr = addr;
		apbReq.wdata = wdata;
		@(posedge clk);
		#1;
		apbReq.enable = 1'b1;
		// the response is combinational and has settled by the falling edge.
		@(negedge clk);
		rdata = apbRsp.rdata;
		err = apbRsp.slverr;
		checkErr("apbRsp.ready", 1'b1, apbRsp.ready);
		@(posedge clk);
		#1;
		apbReq = '0;
	endtask

	task automatic apbWrite(input logic [11:0] addr, input logic [31:0] wdata, output logic err);
		logic [31:0] unused;
		apbCycle(1'b1, addr, wdata, unused, err);
	endtask

	task automatic apbRead(input logic [11:0] addr, output logic [31:0] rdata, output logic err);
		apbCycle(1'b0, addr, 32'h0, rdata, err);
	endtask

	task automatic writeOk(input logic [11:0] addr, input logic [31:0] wdata);
		logic err;
		apbWrite(addr, wdata, err);
		checkErr($sformatf("slverr write %03h", addr), 1'b0, err);
	endtask

	task automatic readExpect(input string name, input logic [11:0] addr, input logic [31:0] exp);
		logic [31:0] data;
		logic err;
		apbRead(addr, data, err);
		checkErr({name, " slverr"}, 1'b0, err);
		checkWord(name, exp, data);
	endtask

	task automatic loadConfig();
		for (int i = 0; i < numInputs; i++)
			writeOk(regAddr(addrInput, i), {24'b0, inVec[i]});
		for (int n = 0; n < numHidden; n++)
		begin
			writeOk(regAddr(addrHiddenBias, n), {{16{hb[n][15]}}, hb[n]});
			for (int i = 0; i < numInputs; i++)
				writeOk(regAddr(addrHiddenWeight, n * numInputs + i), {24'b0, hw[n][i]});
		end
		for (int o = 0; o < numOutputs; o++)
		begin
			writeOk(regAddr(addrOutBias, o), {16'b0, ob[o]});
			for (int h = 0; h < numHidden; h++)
				writeOk(regAddr(addrOutWeight, o * numHidden + h), {24'b0, ow[o][h]});
		end
	endtask

	// inputs zero-extend, weights and biases sign-extend.
	task automatic verifyReadback();
		for (int i = 0; i < numInputs; i++)
			readExpect($sformatf("input[%0d]", i), regAddr(addrInput, i), {24'b0, inVec[i]});
		for (int n = 0; n < numHidden; n++)
		begin
			readExpect($sformatf("hiddenBias[%0d]", n), regAddr(addrHiddenBias, n),
				{{16{hb[n][15]}}, hb[n]});
			for (int i = 0; i < numInputs; i++)
				readExpect($sformatf("hiddenWeight[%0d][%0d]", n, i),
					regAddr(addrHiddenWeight, n * numInputs + i), {{24{hw[n][i][7]}}, hw[n][i]});
		end
		for (int o = 0; o < numOutputs; o++)
		begin
			readExpect($sformatf("outBias[%0d]", o), regAddr(addrOutBias, o),
				{{16{ob[o][15]}}, ob[o]});
			for (int h = 0; h < numHidden; h++)
				readExpect($sformatf("outWeight[%0d][%0d]", o, h),
					regAddr(addrOutWeight, o * numHidden + h), {{24{ow[o][h][7]}}, ow[o][h]});
		end
	endtask

	task automatic waitDone();
		logic [31:0] data;
		logic err;
		int polls;
		polls = 0;
		data = '0;
		while (data[0] !== 1'b1 && polls < 40)
		begin
			apbRead(addrStatus, data, err);
			polls++;
		end
		if (data[0] !== 1'b1)
		begin
			errors++;
			$display("Timeout at %0t: done flag was never set after start", $time);
		end
	endtask

	task automatic checkResults();
		logic [31:0] data;
		logic err;
		for (int o = 0; o < numOutputs; o++)
		begin
			apbRead(regAddr(addrResult, o), data, err);
			checkErr($sformatf("result[%0d] slverr", o), 1'b0, err);
			checkAct($sformatf("result[%0d]", o), refInfer(o), data[7:0]);
		end
	endtask

	task automatic runInference();
		writeOk(addrCtrl, 32'h1);
		waitDone();
		checkResults();
	endtask

	task automatic fixedConfig();
		for (int i = 0; i < numInputs; i++)
			inVec[i] = actT'(i * 3 + 1);
		for (int n = 0; n < numHidden; n++)
		begin
			hb[n] = biasT'(n * 50 - 20);
			for (int i = 0; i < numInputs; i++)
				if (n == 1)
					hw[n][i] = -8'sd4;
				else
					hw[n][i] = weightT'((n + i) % 5 - 1);
		end
		for (int o = 0; o < numOutputs; o++)
		begin
			ob[o] = biasT'(o * 16 - 8);
			for (int h = 0; h < numHidden; h++)
				ow[o][h] = weightT'(o * 2 + h + 1);
		end
	endtask

	task automatic randomConfig();
		for (int i = 0; i < numInputs; i++)
		begin
			rngState = xorshift(rngState);
			inVec[i] = rngState[7:0];
		end
		for (int n = 0; n < numHidden; n++)
		begin
			rngState = xorshift(rngState);
			hb[n] = $signed(rngState[31:16]) >>> 3;
			for (int i = 0; i < numInputs; i++)
			begin
				rngState = xorshift(rngState);
				hw[n][i] = $signed(rngState[15:8]) >>> 2;
			end
		end
		for (int o = 0; o < numOutputs; o++)
		begin
			rngState = xorshift(rngState);
			ob[o] = $signed(rngState[31:16]) >>> 3;
			for (int h = 0; h < numHidden; h++)
			begin
				rngState = xorshift(rngState);
				ow[o][h] = $signed(rngState[15:8]) >>> 2;
			end
		end
	endtask

	initial
	begin
		reset = 1'b1;
		apbReq = '0;
		errors = 0;
		checks = 0;
		rngState = 32'h1bfd_fb11;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		readExpect("status after reset", addrStatus, 32'h0);
		readExpect("result[0] after reset", regAddr(addrResult, 0), 32'h0);
		fixedConfig();
		loadConfig();
		verifyReadback();

		// hidden neuron 1 has only negative weights and must clamp to zero.
		runInference();
		checkAct("u_dut.hiddenActs[1]", 8'd0, u_dut.hiddenActs[1]);

		writeOk(addrCtrl, 32'h1);
		readExpect("status right after start", addrStatus, 32'h0);
		repeat (3) @(posedge clk);
		#1;
		readExpect("status after pipeline", addrStatus, 32'h1);
		checkResults();

		for (int i = 0; i < numInputs; i++)
			inVec[i] = 8'd255;
		for (int n = 0; n < numHidden; n++)
		begin
			hb[n] = '0;
			for (int i = 0; i < numInputs; i++)
				hw[n][i] = 8'sd127;
		end
		for (int o = 0; o < numOutputs; o++)
		begin
			ob[o] = '0;
			for (int h = 0; h < numHidden; h++)
				ow[o][h] = 8'sd127;
		end
		loadConfig();
		runInference();
		readExpect("saturated result[0]", regAddr(addrResult, 0), 32'd255);

		for (int k = 0; k < 20; k++)
		begin
			randomConfig();
			loadConfig();
			runInference();
		end

		apbRead(12'h03c, rd, er);
		checkErr("slverr read unmapped 03c", 1'b1, er);
		apbWrite(12'h07c, 32'h0000_00aa, er);
		checkErr("slverr write unmapped 07c", 1'b1, er);
		apbWrite(12'h3f0, 32'h0000_0055, er);
		checkErr("slverr write unmapped 3f0", 1'b1, er);
		apbWrite(12'h042, 32'h0000_0011, er);
		checkErr("slverr write misaligned 042", 1'b1, er);
		apbWrite(addrStatus, 32'h0, er);
		checkErr("slverr write status", 1'b1, er);
		apbWrite(regAddr(addrResult, 1), 32'h0000_00c3, er);
		checkErr("slverr write result[1]", 1'b1, er);
		readExpect("status after bad writes", addrStatus, 32'h1);
		checkResults();
		verifyReadback();

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
